//--- Bender.yml
package:
  name: pim_conv

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/pim_conv_pkg.sv
      - verilog/pim_macro.sv
      - verilog/pim_conv3x3.sv

  - target: test
    include_dirs:
      - verilog
    files:
      - dv/pim_conv_assertions.sv
      - dv/pim_conv_tb.sv

//--- dv/pim_conv_assertions.sv
`timescale 1ns/1ps

`include "pim_settings.svh"

module pim_conv_assertions
  import pim_conv_pkg::*;
(
  input logic                   clk,
  input logic                   arst_n,
  input logic                   wr_en,
  input logic [`PIM_ADDR_W-1:0] wr_addr,
  input kernel_t                wr_kernel,
  input logic                   compute,
  input logic [`PIM_ADDR_W-1:0] addr,
  input window_t                window,
  input logic [`PIM_OUT_W-1:0]  out_data,
  input logic                   out_valid
);

  localparam int unsigned CODE_MAX = (1 << `PIM_ADC_BITS) - 1;
  localparam logic [`PIM_OUT_W-1:0] SAT_RESULT = `PIM_OUT_W'(20655);  // 255 * (64 + 8 + 8 + 1)

  int unsigned err_count = 0;

  kernel_t shadow [`PIM_DEPTH];  // mirror of the stored kernels
  kernel_t kern_now;             // kernel a compute in this cycle reads
  logic    seen_compute;

  // x * w split into 3 bit halves, each half product clipped like the adc
  function automatic logic [`PIM_OUT_W-1:0] conv_rule(input window_t w, input kernel_t k);
    int unsigned hh;
    int unsigned hl;
    int unsigned lh;
    int unsigned ll;
    int unsigned total;
    hh = 0;
    hl = 0;
    lh = 0;
    ll = 0;
    for (int i = 0; i < 9; i++)
    begin
      hh += (w[i].word / 8) * (k[i].word / 8);
      hl += (w[i].word / 8) * (k[i].word % 8);
      lh += (w[i].word % 8) * (k[i].word / 8);
      ll += (w[i].word % 8) * (k[i].word % 8);
    end
    if (hh > CODE_MAX) hh = CODE_MAX;
    if (hl > CODE_MAX) hl = CODE_MAX;
    if (lh > CODE_MAX) lh = CODE_MAX;
    if (ll > CODE_MAX) ll = CODE_MAX;
    total = hh * 64 + (hl + lh) * 8 + ll;
    return `PIM_OUT_W'(total);
  endfunction

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      for (int k = 0; k < `PIM_DEPTH; k++)
        shadow[k] <= '0;
      seen_compute <= 1'b0;
    end
    else
    begin
      if (wr_en)
        shadow[wr_addr] <= wr_kernel;  // lands after this edge, so reads see old data
      if (compute)
        seen_compute <= 1'b1;
    end
  end

  assign kern_now = shadow[addr];

  a_no_spurious_valid: assert property (@(posedge clk) disable iff (!arst_n)
    !$past(compute, 2) |-> !out_valid)
    else
    begin
      err_count++;
      $error("FAILED at %0t: out_valid got %0b expected 0", $time, $sampled(out_valid));
    end

  a_valid_after_compute: assert property (@(posedge clk) disable iff (!arst_n)
    compute |-> ##2 out_valid)
    else
    begin
      err_count++;
      $error("out_valid did not pulse two cycles after a compute at %0t", $time);
    end

  a_zero_before_compute: assert property (@(posedge clk) disable iff (!arst_n)
    !seen_compute |-> out_data == '0)
    else
    begin
      err_count++;
      $error("FAILED at %0t: out_data got %0d expected 0", $time, $sampled(out_data));
    end

  a_data_rule: assert property (@(posedge clk) disable iff (!arst_n)
    out_valid |-> out_data == conv_rule($past(window, 2), $past(kern_now, 2)))
    else
    begin
      err_count++;
      $error("FAILED at %0t: out_data got %0d expected %0d", $time, $sampled(out_data),
             conv_rule($past(window, 2), $past(kern_now, 2)));
    end

  // all 63s, every slice sum is 441 and clips
  a_saturated: assert property (@(posedge clk) disable iff (!arst_n)
    out_valid && $past(window, 2) == '1 && $past(kern_now, 2) == '1
      |-> out_data == SAT_RESULT)
    else
    begin
      err_count++;
      $error("FAILED at %0t: out_data got %0d expected %0d", $time, $sampled(out_data),
             SAT_RESULT);
    end

endmodule

//--- dv/pim_conv_tb.sv
`timescale 1ns/1ps

`include "pim_settings.svh"

module pim_conv_tb
  import pim_conv_pkg::*;
();

  localparam int unsigned TIMEOUT_CYCLES = 3000;  // stimulus runs about 1300
  localparam int unsigned RANDOM_CYCLES  = 1200;

  logic                   clk;
  logic                   arst_n;
  logic                   wr_en;
  logic [`PIM_ADDR_W-1:0] wr_addr;
  kernel_t                wr_kernel;
  logic                   compute;
  logic [`PIM_ADDR_W-1:0] addr;
  window_t                window;
  logic [`PIM_OUT_W-1:0]  out_data;
  logic                   out_valid;

  logic [31:0] lcg_state = 32'ha411;
  int unsigned cycle_count = 0;
  int unsigned compute_count = 0;

  pim_conv3x3 UUT (
    .clk       (clk),
    .arst_n    (arst_n),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_kernel (wr_kernel),
    .compute   (compute),
    .addr      (addr),
    .window    (window),
    .out_data  (out_data),
    .out_valid (out_valid)
  );

  bind pim_conv3x3 pim_conv_assertions u_chk (
    .clk       (clk),
    .arst_n    (arst_n),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_kernel (wr_kernel),
    .compute   (compute),
    .addr      (addr),
    .window    (window),
    .out_data  (out_data),
    .out_valid (out_valid)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // nine random 6 bit taps, upper lcg bits are the better ones
  function automatic window_t random_taps();
    window_t taps;
    logic [31:0] r;
    for (int i = 0; i < 9; i++)
    begin
      r = next_random();
      taps[i].word = r[31:26];
    end
    return taps;
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic load_kernel(input logic [`PIM_ADDR_W-1:0] a, input kernel_t k);
    wr_en     = 1'b1;
    wr_addr   = a;
    wr_kernel = k;
    next_cycle();
    wr_en = 1'b0;
  endtask

  task automatic issue_compute(input logic [`PIM_ADDR_W-1:0] a, input window_t w);
    compute = 1'b1;
    addr    = a;
    window  = w;
    compute_count++;
    next_cycle();
    compute = 1'b0;
  endtask

  // write and compute hit one address in the same cycle, then compute again
  task automatic write_then_reread(input logic [`PIM_ADDR_W-1:0] a, input kernel_t k,
                                   input window_t w);
    wr_en     = 1'b1;
    wr_addr   = a;
    wr_kernel = k;
    issue_compute(a, w);
    wr_en = 1'b0;
    issue_compute(a, w);
  endtask

  task automatic drain();
    repeat (4) next_cycle();
  endtask

  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == TIMEOUT_CYCLES)
    begin
      $display("timeout: run still going after %0d cycles, %0d assertion failures",
               TIMEOUT_CYCLES, UUT.u_chk.err_count);
      $display("Test failures found");
      $finish;
    end
  end

  initial
  begin
    kernel_t     k;
    window_t     w;
    logic [31:0] r;
    arst_n    = 1'b0;
    wr_en     = 1'b0;
    wr_addr   = '0;
    wr_kernel = '0;
    compute   = 1'b0;
    addr      = '0;
    window    = '0;
    repeat (8) @(posedge clk);
    #1;
    arst_n = 1'b1;

    repeat (6) next_cycle();  // idle outputs after reset

    // full scale on every slice
    load_kernel(0, '1);
    issue_compute(0, '1);
    drain();

    // one fixed window against four different kernels
    for (int a = 0; a < `PIM_DEPTH; a++)
    begin
      for (int i = 0; i < 9; i++)
        k[i].word = 6'(8 * a + i + 3);
      load_kernel(`PIM_ADDR_W'(a), k);
    end
    for (int i = 0; i < 9; i++)
      w[i].word = 6'(5 * i + 2);
    for (int a = 0; a < `PIM_DEPTH; a++)
      issue_compute(`PIM_ADDR_W'(a), w);   // back to back
    drain();

    // read before write on a shared address
    k = random_taps();
    write_then_reread(2, k, w);
    drain();

    for (int a = 0; a < `PIM_DEPTH; a++)
      load_kernel(`PIM_ADDR_W'(a), random_taps());

    // random mix of computes, gaps and kernel updates
    repeat (RANDOM_CYCLES)
    begin
      r         = next_random();
      compute   = r[31] | r[30];
      addr      = r[29:28];
      window    = random_taps();
      wr_en     = (r[27:25] == 3'd0);
      wr_addr   = r[24:23];
      wr_kernel = random_taps();
      if (compute)
        compute_count++;
      next_cycle();
    end
    compute = 1'b0;
    wr_en   = 1'b0;
    drain();

    $display("%0d assertion failures, %0d computes issued, %0d cycles",
             UUT.u_chk.err_count, compute_count, cycle_count);
    if (UUT.u_chk.err_count == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

//--- list.f
+incdir+verilog
verilog/pim_conv_pkg.sv
verilog/pim_macro.sv
verilog/pim_conv3x3.sv
dv/pim_conv_assertions.sv
dv/pim_conv_tb.sv

//--- verilog/pim_conv3x3.sv
`timescale 1ns/1ps

`include "pim_settings.svh"

module pim_conv3x3
  import pim_conv_pkg::*;
(
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   wr_en,
  input  logic [`PIM_ADDR_W-1:0] wr_addr,
  input  kernel_t                wr_kernel,
  input  logic                   compute,
  input  logic [`PIM_ADDR_W-1:0] addr,
  input  window_t                window,
  output logic [`PIM_OUT_W-1:0]  out_data,
  output logic                   out_valid
);

  localparam int HH_SHIFT  = 2 * SLICE_W;  // hi * hi
  localparam int MID_SHIFT = SLICE_W;      // hi * lo and lo * hi

  slice_win_t act_hi;
  slice_win_t act_lo;
  slice_win_t w_hi;
  slice_win_t w_lo;

  adc_quad_t codes;
  logic      hh_valid;

  logic [`PIM_OUT_W-1:0] hh_term;
  logic [`PIM_OUT_W-1:0] mid_term;
  logic [`PIM_OUT_W-1:0] ll_term;
  logic [`PIM_OUT_W-1:0] sum;

  // bit slicing of window and kernel
  always_comb
  begin
    for (int i = 0; i < TAPS; i++)
    begin
      act_hi[i] = window[i].part.hi;
      act_lo[i] = window[i].part.lo;
      w_hi[i]   = wr_kernel[i].part.hi;
      w_lo[i]   = wr_kernel[i].part.lo;
    end
  end

  // high activation with high weight
  pim_macro u_hh (
    .clk        (clk),
    .arst_n     (arst_n),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .wr_slice   (w_hi),
    .compute    (compute),
    .addr       (addr),
    .act        (act_hi),
    .code       (codes.hh),
    .code_valid (hh_valid)
  );

  // the other three strobe in lockstep with u_hh
  pim_macro u_hl (
    .clk        (clk),
    .arst_n     (arst_n),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .wr_slice   (w_lo),
    .compute    (compute),
    .addr       (addr),
    .act        (act_hi),
    .code       (codes.hl),
    .code_valid ()
  );

  pim_macro u_lh (
    .clk        (clk),
    .arst_n     (arst_n),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .wr_slice   (w_hi),
    .compute    (compute),
    .addr       (addr),
    .act        (act_lo),
    .code       (codes.lh),
    .code_valid ()
  );

  pim_macro u_ll (
    .clk        (clk),
    .arst_n     (arst_n),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .wr_slice   (w_lo),
    .compute    (compute),
    .addr       (addr),
    .act        (act_lo),
    .code       (codes.ll),
    .code_valid ()
  );

  // shift-add of the four codes
  // x * w = 64 xh wh + 8 (xh wl + xl wh) + xl wl
  assign hh_term  = `PIM_OUT_W'(codes.hh) << HH_SHIFT;
  assign mid_term = (`PIM_OUT_W'(codes.hl) + `PIM_OUT_W'(codes.lh)) << MID_SHIFT;
  assign ll_term  = `PIM_OUT_W'(codes.ll);
  assign sum      = hh_term + mid_term + ll_term;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      out_data  <= '0;
      out_valid <= 1'b0;
    end
    else
    begin
      out_valid <= hh_valid;  // compute + 2
      if (hh_valid)
        out_data <= sum;
    end
  end

endmodule

//--- verilog/pim_conv_pkg.sv
`include "pim_settings.svh"

package pim_conv_pkg;

  localparam int TAPS    = 9;          // 3x3 window
  localparam int SLICE_W = 3;
  localparam int PIX_W   = 2 * SLICE_W;

  // one bit slice of a pixel or weight
  typedef logic [SLICE_W-1:0] slice_t;

  // split view of a 6 bit value
  typedef struct packed {
    slice_t hi;  // bits 5..3
    slice_t lo;  // bits 2..0
  } pix_part_t;

  // activation or weight, read whole or as two slices
  typedef union packed {
    logic [PIX_W-1:0] word;
    pix_part_t        part;
  } pix_t;

  // row-major, element 0 is the top-left tap
  typedef pix_t [TAPS-1:0] window_t;

  // weights in the same tap order as window_t
  typedef pix_t [TAPS-1:0] kernel_t;

  // one slice taken from every tap
  typedef slice_t [TAPS-1:0] slice_win_t;

  typedef logic [`PIM_ADC_BITS-1:0] adc_code_t;

  // full scale adc code, the saturation point
  localparam adc_code_t ADC_MAX = '1;

  // the four cross-product codes of one window
  typedef struct packed {
    adc_code_t hh;  // weight 64
    adc_code_t hl;  // weight 8
    adc_code_t lh;  // weight 8
    adc_code_t ll;  // weight 1
  } adc_quad_t;

endpackage

//--- verilog/pim_macro.sv
`timescale 1ns/1ps

`include "pim_settings.svh"

module pim_macro
  import pim_conv_pkg::*;
(
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   wr_en,
  input  logic [`PIM_ADDR_W-1:0] wr_addr,
  input  slice_win_t             wr_slice,
  input  logic                   compute,
  input  logic [`PIM_ADDR_W-1:0] addr,
  input  slice_win_t             act,
  output adc_code_t              code,
  output logic                   code_valid
);

  localparam int PROD_W = 2 * SLICE_W;            // 7 * 7 = 49
  localparam int SUM_W  = PROD_W + $clog2(TAPS);  // room for 9 products

  // weight slices, one entry per stored kernel
  slice_win_t mem [`PIM_DEPTH];

  slice_win_t            sel_w;        // kernel picked by addr
  logic [PROD_W-1:0]     prod [TAPS];  // per-cell products
  logic [SUM_W-1:0]      dot_sum;      // analog column sum
  adc_code_t             adc_code;

  // adc model, clips at full scale
  function automatic adc_code_t adc_sat(input logic [SUM_W-1:0] s);
    adc_code_t res;
    if (s > SUM_W'(ADC_MAX))
      res = ADC_MAX;
    else
      res = adc_code_t'(s);
    return res;
  endfunction

  // weight load
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      for (int k = 0; k < `PIM_DEPTH; k++)
        mem[k] <= '0;
    end
    else if (wr_en)
    begin
      mem[wr_addr] <= wr_slice;
    end
  end

  // read is combinational so a same cycle write is not seen yet
  assign sel_w = mem[addr];

  always_comb
  begin
    for (int i = 0; i < TAPS; i++)
      prod[i] = PROD_W'(act[i]) * PROD_W'(sel_w[i]);
  end

  // accumulate along the column
  always_comb
  begin
    dot_sum = '0;
    for (int i = 0; i < TAPS; i++)
      dot_sum = dot_sum + SUM_W'(prod[i]);
  end

  assign adc_code = adc_sat(dot_sum);

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      code       <= '0;
      code_valid <= 1'b0;
    end
    else
    begin
      code_valid <= compute;      // one pulse per compute
      if (compute)
        code <= adc_code;         // hold last code otherwise
    end
  end

endmodule

//--- verilog/pim_settings.svh
`ifndef PIM_SETTINGS_SVH
`define PIM_SETTINGS_SVH

// kernels held by each pim macro
`define PIM_DEPTH 4

// kernel address width, must cover PIM_DEPTH
`define PIM_ADDR_W 2

// adc resolution in bits
// a full slice dot product reaches 9 * 7 * 7 = 441
// so an 8 bit adc clips it at 255
`define PIM_ADC_BITS 8

// width of the shift-added result
// 255 * 64 + 2 * 255 * 8 + 255 = 20655 fits in 18 bits
`define PIM_OUT_W 18

`endif
